// File: common/ex_cfg.svh
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// Architectural data width
`define EX_XLEN 64

// Multiplier pipeline depth and bits of multiplier per stage
`define EX_MULT_STAGES 4
`define EX_MULT_CHUNK 16

`endif

// File: common/ex_pkg.sv
`include "ex_cfg.svh"

package ex_pkg;

  // One data word
  typedef logic [`EX_XLEN-1:0] word_t;

  // Architectural destination register
  typedef logic [4:0] reg_idx_t;

  // ALU function codes
  // Code 0x0b stays free since multiplies go to the multiplier
  typedef enum logic [4:0] {
    ADDQ   = 5'h00,
    SUBQ   = 5'h01,
    AND    = 5'h02,
    BIC    = 5'h03,
    BIS    = 5'h04,
    ORNOT  = 5'h05,
    XOR    = 5'h06,
    EQV    = 5'h07,
    SRL    = 5'h08,
    SLL    = 5'h09,
    SRA    = 5'h0a,
    CMPULT = 5'h0c,
    CMPEQ  = 5'h0d,
    CMPULE = 5'h0e,
    CMPLT  = 5'h0f,
    CMPLE  = 5'h10
  } alu_func_e;

  // Low two bits pick the condition and the top bit inverts it
  typedef logic [2:0] br_func_t;

  // Issue class of a decoded operation
  typedef enum logic [1:0] {
    NONE   = 2'b00,
    ALU    = 2'b01,
    BRANCH = 2'b10,
    MULT   = 2'b11
  } op_class_e;

endpackage

// File: common/ex_alu_bus_if.sv
interface ex_alu_bus_if;

  // An ALU or branch operation was accepted this cycle
  logic             valid;
  // Branch operations put link on the bus instead of result
  logic             branch;
  ex_pkg::reg_idx_t dest;
  ex_pkg::word_t    result;
  // Next PC, written back by branches
  ex_pkg::word_t    link;

  // Issue slot side
  modport producer (output valid, branch, dest, result, link);

  // Writeback arbiter side
  modport arbiter (input valid, branch, dest, result, link);

endinterface

// File: alu/ex_alu.sv
module ex_alu (
  input  ex_pkg::word_t     opa,
  input  ex_pkg::word_t     opb,
  input  ex_pkg::alu_func_e func,
  output ex_pkg::word_t     result
);

  // Marker for function codes the ALU does not know
  localparam ex_pkg::word_t BAD_FUNC = 64'hdead_beef_baad_beef;
  localparam int MSB = $bits(ex_pkg::word_t) - 1;

  logic [5:0] shamt;
  logic       ult;
  logic       eq;
  logic       slt;

  // Shift amount from the low six bits of B
  assign shamt = opb[5:0];

  assign ult = opa < opb;
  assign eq  = opa == opb;

  // Same sign, so unsigned order is signed order
  // Otherwise the negative operand is the smaller one
  assign slt = (opa[MSB] == opb[MSB]) ? ult : opa[MSB];

  always_comb
  begin
    case (func)
      ex_pkg::ADDQ:   result = opa + opb;
      ex_pkg::SUBQ:   result = opa - opb;
      ex_pkg::AND:    result = opa & opb;
      ex_pkg::BIC:    result = opa & ~opb;
      ex_pkg::BIS:    result = opa | opb;
      ex_pkg::ORNOT:  result = opa | ~opb;
      ex_pkg::XOR:    result = opa ^ opb;
      ex_pkg::EQV:    result = opa ^ ~opb;
      ex_pkg::SRL:    result = opa >> shamt;
      ex_pkg::SLL:    result = opa << shamt;
      // Sign bit fills from the left
      ex_pkg::SRA:    result = ex_pkg::word_t'($signed(opa) >>> shamt);
      // Compares give 0 or 1
      ex_pkg::CMPULT: result = ex_pkg::word_t'(ult);
      ex_pkg::CMPEQ:  result = ex_pkg::word_t'(eq);
      ex_pkg::CMPULE: result = ex_pkg::word_t'(ult | eq);
      ex_pkg::CMPLT:  result = ex_pkg::word_t'(slt);
      ex_pkg::CMPLE:  result = ex_pkg::word_t'(slt | eq);
      default:        result = BAD_FUNC;
    endcase
  end

endmodule

// File: alu/ex_brcond.sv
module ex_brcond (
  input  ex_pkg::word_t    opa,
  input  ex_pkg::br_func_t func,
  output logic             cond
);

  localparam int MSB = $bits(ex_pkg::word_t) - 1;

  logic raw;

  always_comb
  begin
    case (func[1:0])
      // Low bit clear
      2'b00:   raw = ~opa[0];
      // Equal to zero
      2'b01:   raw = (opa == '0);
      // Negative
      2'b10:   raw = opa[MSB];
      // Negative or zero
      default: raw = opa[MSB] | (opa == '0);
    endcase
  end

  // Top function bit inverts the sense
  assign cond = raw ^ func[2];

endmodule

// File: alu/ex_alu_slot.sv
module ex_alu_slot (
  input  logic              issue_valid,
  input  ex_pkg::op_class_e op_class,
  input  ex_pkg::alu_func_e alu_func,
  input  ex_pkg::br_func_t  br_func,
  input  ex_pkg::word_t     opa,
  input  ex_pkg::word_t     opb,
  input  ex_pkg::word_t     npc,
  input  ex_pkg::reg_idx_t  dest,
  input  logic              stall_bus,
  ex_alu_bus_if.producer    bus,
  output logic              mult_start,
  output logic              br_taken,
  output ex_pkg::word_t     br_target
);

  logic          accept;
  logic          is_branch;
  logic          cond;
  ex_pkg::word_t alu_result;

  ex_alu i_alu (
    .opa    (opa),
    .opb    (opb),
    .func   (alu_func),
    .result (alu_result)
  );

  ex_brcond i_brcond (
    .opa  (opa),
    .func (br_func),
    .cond (cond)
  );

  // Issuer holds the operation while the bus is stalled
  assign accept    = issue_valid & ~stall_bus;
  assign is_branch = (op_class == ex_pkg::BRANCH);

  // ALU and branch results go out in the issue cycle
  assign bus.valid  = accept & ((op_class == ex_pkg::ALU) | is_branch);
  assign bus.branch = is_branch;
  assign bus.dest   = dest;
  assign bus.result = alu_result;
  assign bus.link   = npc;

  // Multiplies leave the slot here and come back through the multiplier
  assign mult_start = accept & (op_class == ex_pkg::MULT);

  // Displacement sits in operand B
  assign br_taken  = accept & is_branch & cond;
  assign br_target = npc + opb;

endmodule

// File: mult/ex_mult_stage.sv
`include "ex_cfg.svh"

module ex_mult_stage #(
  parameter bit FREEZABLE = 1'b0
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             stall,
  input  logic             start,
  input  ex_pkg::reg_idx_t dest_in,
  input  ex_pkg::word_t    product_in,
  input  ex_pkg::word_t    mplier_in,
  input  ex_pkg::word_t    mcand_in,
  output logic             done,
  output ex_pkg::reg_idx_t dest_out,
  output ex_pkg::word_t    product_out,
  output ex_pkg::word_t    mplier_out,
  output ex_pkg::word_t    mcand_out
);

  logic          hold;
  ex_pkg::word_t partial_product;
  ex_pkg::word_t prod_reg;
  ex_pkg::word_t partial_reg;

  // Stall only matters on a freezable multiplier
  assign hold = FREEZABLE && stall;

  // Low chunk of the multiplier times the already shifted multiplicand
  assign partial_product =
    ex_pkg::word_t'(mplier_in[`EX_MULT_CHUNK-1:0]) * mcand_in;

  always_ff @(posedge clock)
  begin
    if (!hold)
    begin
      prod_reg    <= product_in;
      partial_reg <= partial_product;
      // Next stage sees the next chunk and a multiplicand moved up to match
      mplier_out  <= mplier_in >> `EX_MULT_CHUNK;
      mcand_out   <= mcand_in << `EX_MULT_CHUNK;
      dest_out    <= dest_in;
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      done <= 1'b0;
    else if (!hold)
      done <= start;
  end

  // Running sum with the add after the registers
  assign product_out = prod_reg + partial_reg;

endmodule

// File: mult/ex_mult.sv
`include "ex_cfg.svh"

module ex_mult #(
  parameter bit FREEZABLE = 1'b0
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             stall,
  input  logic             start,
  input  ex_pkg::reg_idx_t dest_in,
  input  ex_pkg::word_t    mplier,
  input  ex_pkg::word_t    mcand,
  output logic             valid_out,
  output ex_pkg::reg_idx_t dest_out,
  output ex_pkg::word_t    product
);

  localparam int N = `EX_MULT_STAGES;

  // Index i feeds stage i, index N is the pipeline output
  logic             done_chain   [0:N];
  ex_pkg::reg_idx_t dest_chain   [0:N];
  ex_pkg::word_t    prod_chain   [0:N];
  ex_pkg::word_t    mplier_chain [0:N];
  ex_pkg::word_t    mcand_chain  [0:N];

  assign done_chain[0]   = start;
  assign dest_chain[0]   = dest_in;
  assign prod_chain[0]   = '0;
  assign mplier_chain[0] = mplier;
  assign mcand_chain[0]  = mcand;

  // Each stage carries its own done bit, so several products can be in flight
  for (genvar i = 0; i < N; i++)
  begin : g_stage
    ex_mult_stage #(
      .FREEZABLE (FREEZABLE)
    ) i_stage (
      .clock       (clock),
      .reset       (reset),
      .stall       (stall),
      .start       (done_chain[i]),
      .dest_in     (dest_chain[i]),
      .product_in  (prod_chain[i]),
      .mplier_in   (mplier_chain[i]),
      .mcand_in    (mcand_chain[i]),
      .done        (done_chain[i+1]),
      .dest_out    (dest_chain[i+1]),
      .product_out (prod_chain[i+1]),
      .mplier_out  (mplier_chain[i+1]),
      .mcand_out   (mcand_chain[i+1])
    );
  end

  // Last sum is the low word of the product
  assign valid_out = done_chain[N];
  assign dest_out  = dest_chain[N];
  assign product   = prod_chain[N];

endmodule

// File: hdl/ex_arbiter.sv
module ex_arbiter (
  ex_alu_bus_if.arbiter    alu_1,
  ex_alu_bus_if.arbiter    alu_2,
  input  logic             mult_valid_1,
  input  logic             mult_valid_2,
  input  ex_pkg::reg_idx_t mult_dest_1,
  input  ex_pkg::reg_idx_t mult_dest_2,
  input  ex_pkg::word_t    mult_product_1,
  input  ex_pkg::word_t    mult_product_2,
  input  logic             mem_valid,
  input  ex_pkg::reg_idx_t mem_tag,
  input  ex_pkg::word_t    mem_value,
  output logic             stall_bus_1,
  output logic             stall_bus_2,
  output logic             stall_mult_2,
  output logic             wb_valid_1,
  output logic             wb_valid_2,
  output ex_pkg::reg_idx_t wb_dest_1,
  output ex_pkg::reg_idx_t wb_dest_2,
  output ex_pkg::word_t    wb_result_1,
  output ex_pkg::word_t    wb_result_2
);

  ex_pkg::word_t alu_value_1;
  ex_pkg::word_t alu_value_2;

  // Branches write back their link value
  assign alu_value_1 = alu_1.branch ? alu_1.link : alu_1.result;
  assign alu_value_2 = alu_2.branch ? alu_2.link : alu_2.result;

  // Multiplier 1 wins bus 1 over the slot
  assign wb_valid_1  = mult_valid_1 | alu_1.valid;
  assign wb_dest_1   = mult_valid_1 ? mult_dest_1 : alu_1.dest;
  assign wb_result_1 = mult_valid_1 ? mult_product_1 : alu_value_1;

  // Memory wins bus 2 since a load is never refused
  assign wb_valid_2  = mem_valid | mult_valid_2 | alu_2.valid;
  assign wb_dest_2   = mem_valid ? mem_tag :
                       mult_valid_2 ? mult_dest_2 : alu_2.dest;
  assign wb_result_2 = mem_valid ? mem_value :
                       mult_valid_2 ? mult_product_2 : alu_value_2;

  // Stalls come from registered multiplier state and memory only
  assign stall_bus_1  = mult_valid_1;
  assign stall_bus_2  = mult_valid_2 | mem_valid;
  // Load wins while the finished product waits in multiplier 2
  assign stall_mult_2 = mult_valid_2 & mem_valid;

endmodule

// File: hdl/ex_stage.sv
module ex_stage (
  input  logic              clock,
  input  logic              reset,
  // Slot 1 issue
  input  logic              issue_valid_1,
  input  ex_pkg::op_class_e op_class_1,
  input  ex_pkg::alu_func_e alu_func_1,
  input  ex_pkg::br_func_t  br_func_1,
  input  ex_pkg::word_t     opa_1,
  input  ex_pkg::word_t     opb_1,
  input  ex_pkg::word_t     npc_1,
  input  ex_pkg::reg_idx_t  dest_1,
  output logic              br_taken_1,
  output ex_pkg::word_t     br_target_1,
  // Slot 2 issue
  input  logic              issue_valid_2,
  input  ex_pkg::op_class_e op_class_2,
  input  ex_pkg::alu_func_e alu_func_2,
  input  ex_pkg::br_func_t  br_func_2,
  input  ex_pkg::word_t     opa_2,
  input  ex_pkg::word_t     opb_2,
  input  ex_pkg::word_t     npc_2,
  input  ex_pkg::reg_idx_t  dest_2,
  output logic              br_taken_2,
  output ex_pkg::word_t     br_target_2,
  // Load results, always on bus 2
  input  logic              mem_valid,
  input  ex_pkg::reg_idx_t  mem_tag,
  input  ex_pkg::word_t     mem_value,
  // Stalls back to issue
  output logic              stall_bus_1,
  output logic              stall_bus_2,
  output logic              stall_mult_2,
  // Writeback buses
  output logic              wb_valid_1,
  output ex_pkg::reg_idx_t  wb_dest_1,
  output ex_pkg::word_t     wb_result_1,
  output logic              wb_valid_2,
  output ex_pkg::reg_idx_t  wb_dest_2,
  output ex_pkg::word_t     wb_result_2
);

  logic             mult_start_1;
  logic             mult_start_2;
  logic             mult_valid_1;
  logic             mult_valid_2;
  ex_pkg::reg_idx_t mult_dest_1;
  ex_pkg::reg_idx_t mult_dest_2;
  ex_pkg::word_t    mult_product_1;
  ex_pkg::word_t    mult_product_2;

  ex_alu_bus_if alu_bus_1 ();
  ex_alu_bus_if alu_bus_2 ();

  ex_alu_slot i_slot_1 (
    .issue_valid (issue_valid_1),
    .op_class    (op_class_1),
    .alu_func    (alu_func_1),
    .br_func     (br_func_1),
    .opa         (opa_1),
    .opb         (opb_1),
    .npc         (npc_1),
    .dest        (dest_1),
    .stall_bus   (stall_bus_1),
    .bus         (alu_bus_1.producer),
    .mult_start  (mult_start_1),
    .br_taken    (br_taken_1),
    .br_target   (br_target_1)
  );

  ex_alu_slot i_slot_2 (
    .issue_valid (issue_valid_2),
    .op_class    (op_class_2),
    .alu_func    (alu_func_2),
    .br_func     (br_func_2),
    .opa         (opa_2),
    .opb         (opb_2),
    .npc         (npc_2),
    .dest        (dest_2),
    .stall_bus   (stall_bus_2),
    .bus         (alu_bus_2.producer),
    .mult_start  (mult_start_2),
    .br_taken    (br_taken_2),
    .br_target   (br_target_2)
  );

  // Bus 1 never blocks a product, so multiplier 1 runs free
  ex_mult #(
    .FREEZABLE (1'b0)
  ) i_mult_1 (
    .clock     (clock),
    .reset     (reset),
    .stall     (1'b0),
    .start     (mult_start_1),
    .dest_in   (dest_1),
    .mplier    (opa_1),
    .mcand     (opb_1),
    .valid_out (mult_valid_1),
    .dest_out  (mult_dest_1),
    .product   (mult_product_1)
  );

  // Frozen while a load owns bus 2
  ex_mult #(
    .FREEZABLE (1'b1)
  ) i_mult_2 (
    .clock     (clock),
    .reset     (reset),
    .stall     (stall_mult_2),
    .start     (mult_start_2),
    .dest_in   (dest_2),
    .mplier    (opa_2),
    .mcand     (opb_2),
    .valid_out (mult_valid_2),
    .dest_out  (mult_dest_2),
    .product   (mult_product_2)
  );

  ex_arbiter i_arbiter (
    .alu_1          (alu_bus_1.arbiter),
    .alu_2          (alu_bus_2.arbiter),
    .mult_valid_1   (mult_valid_1),
    .mult_valid_2   (mult_valid_2),
    .mult_dest_1    (mult_dest_1),
    .mult_dest_2    (mult_dest_2),
    .mult_product_1 (mult_product_1),
    .mult_product_2 (mult_product_2),
    .mem_valid      (mem_valid),
    .mem_tag        (mem_tag),
    .mem_value      (mem_value),
    .stall_bus_1    (stall_bus_1),
    .stall_bus_2    (stall_bus_2),
    .stall_mult_2   (stall_mult_2),
    .wb_valid_1     (wb_valid_1),
    .wb_valid_2     (wb_valid_2),
    .wb_dest_1      (wb_dest_1),
    .wb_dest_2      (wb_dest_2),
    .wb_result_1    (wb_result_1),
    .wb_result_2    (wb_result_2)
  );

endmodule

// File: verif/ex_stage_tb.sv
module ex_stage_tb;

  localparam int    HALF_PERIOD  = 10;
  localparam int    RESET_CYCLES = 10;
  localparam int    SLACK_CYCLES = 20;
  // Inputs and expected outputs on one vector line
  localparam int    FIELDS       = 28;
  localparam string VEC_FILE     = "verif/ex_stage_input.txt";

  logic              clock;
  logic              reset;
  logic              issue_valid_1;
  ex_pkg::op_class_e op_class_1;
  ex_pkg::alu_func_e alu_func_1;
  ex_pkg::br_func_t  br_func_1;
  ex_pkg::word_t     opa_1;
  ex_pkg::word_t     opb_1;
  ex_pkg::word_t     npc_1;
  ex_pkg::reg_idx_t  dest_1;
  logic              br_taken_1;
  ex_pkg::word_t     br_target_1;
  logic              issue_valid_2;
  ex_pkg::op_class_e op_class_2;
  ex_pkg::alu_func_e alu_func_2;
  ex_pkg::br_func_t  br_func_2;
  ex_pkg::word_t     opa_2;
  ex_pkg::word_t     opb_2;
  ex_pkg::word_t     npc_2;
  ex_pkg::reg_idx_t  dest_2;
  logic              br_taken_2;
  ex_pkg::word_t     br_target_2;
  logic              mem_valid;
  ex_pkg::reg_idx_t  mem_tag;
  ex_pkg::word_t     mem_value;
  logic              stall_bus_1;
  logic              stall_bus_2;
  logic              stall_mult_2;
  logic              wb_valid_1;
  ex_pkg::reg_idx_t  wb_dest_1;
  ex_pkg::word_t     wb_result_1;
  logic              wb_valid_2;
  ex_pkg::reg_idx_t  wb_dest_2;
  ex_pkg::word_t     wb_result_2;

  // All vector lines back to back with FIELDS words each
  logic [63:0] fields [$];
  // Fields of the current line
  logic [63:0] vf [0:FIELDS-1];
  int          n_vectors;
  int          vec_num;
  int          cycle_count;
  int          cycle_limit;

  ex_stage i_dut (
    .clock         (clock),
    .reset         (reset),
    .issue_valid_1 (issue_valid_1),
    .op_class_1    (op_class_1),
    .alu_func_1    (alu_func_1),
    .br_func_1     (br_func_1),
    .opa_1         (opa_1),
    .opb_1         (opb_1),
    .npc_1         (npc_1),
    .dest_1        (dest_1),
    .br_taken_1    (br_taken_1),
    .br_target_1   (br_target_1),
    .issue_valid_2 (issue_valid_2),
    .op_class_2    (op_class_2),
    .alu_func_2    (alu_func_2),
    .br_func_2     (br_func_2),
    .opa_2         (opa_2),
    .opb_2         (opb_2),
    .npc_2         (npc_2),
    .dest_2        (dest_2),
    .br_taken_2    (br_taken_2),
    .br_target_2   (br_target_2),
    .mem_valid     (mem_valid),
    .mem_tag       (mem_tag),
    .mem_value     (mem_value),
    .stall_bus_1   (stall_bus_1),
    .stall_bus_2   (stall_bus_2),
    .stall_mult_2  (stall_mult_2),
    .wb_valid_1    (wb_valid_1),
    .wb_dest_1     (wb_dest_1),
    .wb_result_1   (wb_result_1),
    .wb_valid_2    (wb_valid_2),
    .wb_dest_2     (wb_dest_2),
    .wb_result_2   (wb_result_2)
  );

  initial
  begin
    clock = 1'b0;
    forever
      #HALF_PERIOD clock = ~clock;
  end

  task automatic stop_on_failure();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on a failure");
  endtask

  task automatic report_mismatch(input string msg);
    $display("** Error at time %0t: vector %0d: %s", $time, vec_num, msg);
    stop_on_failure();
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
  endtask

  task automatic check_bus(input string name,
                           input ex_pkg::reg_idx_t got_dest,
                           input ex_pkg::word_t got_result,
                           input ex_pkg::reg_idx_t exp_dest,
                           input ex_pkg::word_t exp_result);
    if (got_dest !== exp_dest || got_result !== exp_result)
      report_mismatch($sformatf("%s carries r%0d = %h, expected r%0d = %h",
                                name, got_dest, got_result, exp_dest, exp_result));
  endtask

  task automatic check_branch(input string name,
                              input logic got_taken,
                              input ex_pkg::word_t got_target,
                              input logic exp_taken,
                              input ex_pkg::word_t exp_target,
                              input logic check_target);
    check_flag({name, " taken"}, got_taken, exp_taken);
    if (check_target && got_target !== exp_target)
      report_mismatch($sformatf("%s target is %h, expected %h",
                                name, got_target, exp_target));
  endtask

  // Idle issue slots with no load and reset held
  task automatic idle_inputs();
    reset         = 1'b1;
    issue_valid_1 = 1'b0;
    op_class_1    = ex_pkg::NONE;
    alu_func_1    = ex_pkg::ADDQ;
    br_func_1     = '0;
    opa_1         = '0;
    opb_1         = '0;
    npc_1         = '0;
    dest_1        = '0;
    issue_valid_2 = 1'b0;
    op_class_2    = ex_pkg::NONE;
    alu_func_2    = ex_pkg::ADDQ;
    br_func_2     = '0;
    opa_2         = '0;
    opb_2         = '0;
    npc_2         = '0;
    dest_2        = '0;
    mem_valid     = 1'b0;
    mem_tag       = '0;
    mem_value     = '0;
  endtask

  task automatic load_vectors();
    int    fd;
    int    got;
    string line;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0)
    begin
      $display("Could not open the vector file %s", VEC_FILE);
      stop_on_failure();
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        got = $fgets(line, fd);
        // Comment and blank lines carry no vector
        if (got > 1 && line[0] != "#")
        begin
          got = $sscanf(line,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            vf[0], vf[1], vf[2], vf[3], vf[4], vf[5], vf[6],
            vf[7], vf[8], vf[9], vf[10], vf[11], vf[12], vf[13],
            vf[14], vf[15], vf[16], vf[17], vf[18], vf[19], vf[20],
            vf[21], vf[22], vf[23], vf[24], vf[25], vf[26], vf[27]);
          if (got != FIELDS)
          begin
            $display("A vector line has %0d fields instead of %0d: %s", got, FIELDS, line);
            stop_on_failure();
          end
          else
          begin
            for (int i = 0; i < FIELDS; i++)
              fields.push_back(vf[i]);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Fields 0 to 6 drive slot 1, 7 to 13 slot 2 and 14 to 16 the load
  // Function field feeds both the ALU and the branch unit
  task automatic drive_inputs();
    issue_valid_1 = vf[0][0];
    op_class_1    = ex_pkg::op_class_e'(vf[1][1:0]);
    alu_func_1    = ex_pkg::alu_func_e'(vf[2][4:0]);
    br_func_1     = vf[2][2:0];
    opa_1         = vf[3];
    opb_1         = vf[4];
    npc_1         = vf[5];
    dest_1        = vf[6][4:0];
    issue_valid_2 = vf[7][0];
    op_class_2    = ex_pkg::op_class_e'(vf[8][1:0]);
    alu_func_2    = ex_pkg::alu_func_e'(vf[9][4:0]);
    br_func_2     = vf[9][2:0];
    opa_2         = vf[10];
    opb_2         = vf[11];
    npc_2         = vf[12];
    dest_2        = vf[13][4:0];
    mem_valid     = vf[14][0];
    mem_tag       = vf[15][4:0];
    mem_value     = vf[16];
  endtask

  // Mask bits pick bus 1, bus 2, target 1 and target 2 payloads
  task automatic check_outputs();
    logic [3:0] mask;
    mask = vf[17][3:0];
    check_flag("stall_bus_1", stall_bus_1, vf[18][0]);
    check_flag("stall_bus_2", stall_bus_2, vf[18][1]);
    check_flag("stall_mult_2", stall_mult_2, vf[18][2]);
    check_flag("wb_valid_1", wb_valid_1, vf[19][0]);
    check_flag("wb_valid_2", wb_valid_2, vf[22][0]);
    if (mask[0])
      check_bus("bus 1", wb_dest_1, wb_result_1, vf[20][4:0], vf[21]);
    if (mask[1])
      check_bus("bus 2", wb_dest_2, wb_result_2, vf[23][4:0], vf[24]);
    check_branch("slot 1 branch", br_taken_1, br_target_1, vf[25][0], vf[26], mask[2]);
    check_branch("slot 2 branch", br_taken_2, br_target_2, vf[25][1], vf[27], mask[3]);
  endtask

  // Run limit follows the number of vectors
  initial
  begin
    cycle_count = 0;
    while (cycle_count <= cycle_limit)
    begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout: the run went past %0d clock cycles", cycle_limit);
    stop_on_failure();
  end

  initial
  begin
    idle_inputs();
    load_vectors();
    n_vectors   = fields.size() / FIELDS;
    cycle_limit = RESET_CYCLES + n_vectors + SLACK_CYCLES;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    for (int k = 0; k < n_vectors; k++)
    begin
      // Drive on the falling edge and sample just before the rising edge
      @(negedge clock);
      vec_num = k;
      for (int i = 0; i < FIELDS; i++)
        vf[i] = fields[k * FIELDS + i];
      drive_inputs();
      #(HALF_PERIOD - 1);
      check_outputs();
    end
    if (n_vectors > 0)
    begin
      $display("=== PASS ===");
      $finish;
    end
    else
    begin
      $display("No vectors were found in %s", VEC_FILE);
      stop_on_failure();
    end
  end

endmodule

// File: verif/ex_stage_input.txt
# Slot fields: issue_valid class func opa opb npc dest (slot 1, then slot 2), then load: valid tag value
# Expected: mask stalls wb_valid_1 wb_dest_1 wb_result_1 wb_valid_2 wb_dest_2 wb_result_2 taken tgt_1 tgt_2
# Idle after reset, no valids and no stalls
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0 0 0  0 0 0 0 0 0 0 0 0 0 0
# ALU functions on both slots, result on the bus in the issue cycle
1 1 0 5 7 0 1  1 1 1 3 5 0 2  0 0 0  3 0 1 1 c 1 2 fffffffffffffffe 0 0 0
1 1 2 f0f0 ff00 0 3  1 1 3 f0f0 ff00 0 4  0 0 0  3 0 1 3 f000 1 4 f0 0 0 0
1 1 4 f0f0 0f0f 0 5  1 1 5 0 ffffffffffff0000 0 6  0 0 0  3 0 1 5 ffff 1 6 ffff 0 0 0
1 1 6 ff00 0ff0 0 7  1 1 7 ff00 0ff0 0 8  0 0 0  3 0 1 7 f0f0 1 8 ffffffffffff0f0f 0 0 0
1 1 8 8000000000000000 3f 0 9  1 1 9 1 44 0 a  0 0 0  3 0 1 9 1 1 a 10 0 0 0
1 1 a 8000000000000000 4 0 b  1 1 d 1234 1234 0 c  0 0 0  3 0 1 b f800000000000000 1 c 1 0 0 0
# Signed against unsigned compares with mixed signs
1 1 c ffffffffffffffff 1 0 d  1 1 f ffffffffffffffff 1 0 e  0 0 0  3 0 1 d 0 1 e 1 0 0 0
1 1 e 1 ffffffffffffffff 0 f  1 1 10 1 ffffffffffffffff 0 10  0 0 0  3 0 1 f 1 1 10 0 0 0 0
1 1 a fffffffffffffff0 2 0 11  1 1 c 3 9 0 12  0 0 0  3 0 1 11 fffffffffffffffc 1 12 1 0 0 0
1 1 10 5 5 0 13  1 1 f fffffffffffffffe ffffffffffffffff 0 14  0 0 0  3 0 1 13 1 1 14 1 0 0 0
# Branches with all eight conditions, link on the bus and target npc plus opb
1 2 0 4 20 1000 15  1 2 4 4 ffffffffffffff00 2000 16  0 0 0  f 0 1 15 1000 1 16 2000 1 1020 1f00
1 2 1 0 8 3000 17  1 2 5 0 10 4000 18  0 0 0  f 0 1 17 3000 1 18 4000 1 3008 4010
1 2 2 7 4 5000 19  1 2 6 7 40 6000 1a  0 0 0  f 0 1 19 5000 1 1a 6000 2 5004 6040
1 2 3 ffffffffffffffff c 7000 1b  1 2 7 5 4 8000 1c  0 0 0  f 0 1 1b 7000 1 1c 8000 3 700c 8004
# Back to back multiplies, products four cycles after issue
1 3 0 10001 10001 0 1  1 3 0 ffffffffffffffff 3 0 2  0 0 0  0 0 0 0 0 0 0 0 0 0 0
1 3 0 2 ffffffffffffffff 0 3  1 3 0 123 1000 0 4  0 0 0  0 0 0 0 0 0 0 0 0 0 0
1 3 0 ffff0000 10 0 5  0 0 0 0 0 0 0  0 0 0  0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0 0 0  0 0 0 0 0 0 0 0 0 0 0
# Products take the buses, slot 1 holds its add until stall_bus_1 drops
1 1 0 1 1 0 1e  0 0 0 0 0 0 0  0 0 0  3 3 1 1 100020001 1 2 fffffffffffffffd 0 0 0
1 1 0 1 1 0 1e  0 0 0 0 0 0 0  0 0 0  3 3 1 3 fffffffffffffffe 1 4 123000 0 0 0
1 1 0 1 1 0 1e  0 0 0 0 0 0 0  0 0 0  1 1 1 5 ffff00000 0 0 0 0 0 0
1 1 0 1 1 0 1e  0 0 0 0 0 0 0  0 0 0  1 0 1 1e 2 0 0 0 0 0 0
# Loads collide with a finished slot 2 product, which waits in multiplier 2
0 0 0 0 0 0 0  1 3 0 6 7 0 7  0 0 0  0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0 0 0  0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0 0 0  0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0 0 0  0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0  0 0 0 0 0 0 0  1 8 abcd  2 6 0 0 0 1 8 abcd 0 0 0
0 0 0 0 0 0 0  0 0 0 0 0 0 0  1 9 beef  2 6 0 0 0 1 9 beef 0 0 0
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0 0 0  2 2 0 0 0 1 7 2a 0 0 0
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0 0 0  0 0 0 0 0 0 0 0 0 0 0

// File: flist.f
+incdir+common
common/ex_pkg.sv
common/ex_alu_bus_if.sv
alu/ex_alu.sv
alu/ex_brcond.sv
alu/ex_alu_slot.sv
mult/ex_mult_stage.sv
mult/ex_mult.sv
hdl/ex_arbiter.sv
hdl/ex_stage.sv
verif/ex_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench, the output decides the status
cd "$(dirname "$0")" &&
verilator --binary --timing -f flist.f --top-module ex_stage_tb -o ex_stage_sim &&
./obj_dir/ex_stage_sim | tee /dev/stderr | grep -q "^=== PASS ===$" &&
echo "Execute stage simulation succeeded" ||
{ echo "Execute stage simulation did not succeed"; exit 1; }
